// File: hw/sys_ctrl_pkg.sv
// ################################################
// System control package
// Data types and field positions shared by the control
// block, the error sources and the I/O decoder
// ################################################

package sys_ctrl_pkg;

  // widths that carry a meaning
  localparam int WD_CNT_W = 16;                  // watchdog counter

  typedef logic [31:0]         word_t;           // bus data word
  typedef logic [4:0]          pid_t;            // process id
  typedef logic [23:0]         code_addr_t;      // pc and sp width
  typedef logic [7:0]          err_no_t;         // error number
  typedef logic [7:0]          scs_bits_t;       // control/status field
  typedef logic [WD_CNT_W-1:0] wd_cnt_t;         // watchdog count

  // control register layout
  localparam int SCS_RST_BIT = 1;                // reset request
  localparam int CUR_PID_LSB = 8;                // current pid field
  localparam int ERR_PID_LSB = 13;               // error pid field

  // error register layout
  localparam int ERR_ADDR_LSB = 8;               // code address field

  // hardware error lines
  localparam int ERR_LINES   = 8;
  localparam int ERR_WD      = 0;                // watchdog line
  localparam int ERR_STACK   = 1;                // stack monitor line
  localparam int ERR_NO_BASE = 8;                // hw error numbers start here

endpackage

// File: hw/io_map_pkg.sv
// ################################################
// I/O map package
// Word addresses of the system control devices
// ################################################

package io_map_pkg;

  typedef logic [1:0] io_addr_t;                 // I/O word address

  localparam io_addr_t ADDR_SCS_CTRL = 2'd0;     // control/status
  localparam io_addr_t ADDR_SCS_ERR  = 2'd1;     // error record
  localparam io_addr_t ADDR_WD       = 2'd2;     // watchdog count
  localparam io_addr_t ADDR_STACK    = 2'd3;     // stack limit

endpackage

// File: hw/dev_bus_if.sv
// ################################################
// Device bus interface
// Select, write strobe, sub-address and data between
// the I/O decoder and one device
// ################################################

`timescale 1ns/100ps

interface dev_bus_if;
  import sys_ctrl_pkg::*;

  logic  sel;                                    // device addressed, strobe up
  logic  we;                                     // write cycle
  logic  sub;                                    // low address bit
  word_t wdata;
  word_t rdata;                                  // combinational from device

  modport ctrl (
    output sel,
    output we,
    output sub,
    output wdata,
    input  rdata
  );

  modport dev (
    input  sel,
    input  we,
    input  sub,
    input  wdata,
    output rdata
  );

endinterface

// File: hw/scs_regs.sv
// ################################################
// System control and status registers
// Control/status bits, process ids and the error record.
// Captures hardware errors and times a two-cycle
// system reset. Cleared only by the power-on restart.
// ################################################

`timescale 1ns/100ps

module scs_regs (
  input  logic                                clk,
  input  logic                                rst_trig0,
  dev_bus_if.dev                              bus,
  input  logic [sys_ctrl_pkg::ERR_LINES-1:0]  err_sig,
  input  sys_ctrl_pkg::code_addr_t            err_addr,
  output logic                                sys_rst,
  output sys_ctrl_pkg::pid_t                  cp_pid
);
  import sys_ctrl_pkg::*;

  scs_bits_t        scs_q;                       // control and status
  pid_t             cur_pid_q;
  pid_t             err_pid_q;
  code_addr_t       err_addr_q;                  // pc at capture
  err_no_t          err_no_q;
  logic             trig_a;                      // first trigger cycle
  logic             trig_b;                      // second trigger cycle
  logic             wr_ctrl;
  logic             wr_err;
  logic             err_ok;
  int               win_idx;
  word_t            rd_ctrl;
  word_t            rd_err;

  assign wr_ctrl = bus.sel & bus.we & ~bus.sub;
  assign wr_err  = bus.sel & bus.we & bus.sub;

  // no capture while a reset is pending or running
  assign err_ok = ~scs_q[SCS_RST_BIT] & ~trig_a & ~trig_b;

  // highest line wins
  always_comb begin
    win_idx = 0;
    for (int i = 0; i < ERR_LINES; i++) begin
      if (err_sig[i]) begin
        win_idx = i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_trig0) begin
      scs_q      <= '0;
      cur_pid_q  <= '0;
      err_pid_q  <= '0;
      err_addr_q <= '0;
      err_no_q   <= '0;
      trig_a     <= 1'b0;
      trig_b     <= 1'b0;
    end else begin
      trig_a <= scs_q[SCS_RST_BIT];              // request seen for one cycle
      trig_b <= trig_a;
      if (scs_q[SCS_RST_BIT]) begin
        scs_q[SCS_RST_BIT] <= 1'b0;
      end
      if (wr_ctrl) begin
        scs_q     <= bus.wdata[$bits(scs_bits_t)-1:0];
        cur_pid_q <= bus.wdata[CUR_PID_LSB +: $bits(pid_t)];
        err_pid_q <= bus.wdata[ERR_PID_LSB +: $bits(pid_t)];
      end else if (wr_err) begin
        err_addr_q <= bus.wdata[ERR_ADDR_LSB +: $bits(code_addr_t)];
        err_no_q   <= bus.wdata[$bits(err_no_t)-1:0];
      end else if (err_ok && (|err_sig)) begin
        scs_q[SCS_RST_BIT] <= 1'b1;
        err_addr_q         <= err_addr;
        err_no_q           <= err_no_t'(ERR_NO_BASE + win_idx);
      end
    end
  end

  // read-back mirrors the write layout
  always_comb begin
    rd_ctrl = '0;
    rd_ctrl[$bits(scs_bits_t)-1:0]          = scs_q;
    rd_ctrl[CUR_PID_LSB +: $bits(pid_t)]    = cur_pid_q;
    rd_ctrl[ERR_PID_LSB +: $bits(pid_t)]    = err_pid_q;
    rd_err = '0;
    rd_err[ERR_ADDR_LSB +: $bits(code_addr_t)] = err_addr_q;
    rd_err[$bits(err_no_t)-1:0]             = err_no_q;
  end

  assign bus.rdata = bus.sub ? rd_err : rd_ctrl;

  assign sys_rst = rst_trig0 | trig_a | trig_b;  // two-cycle pulse
  assign cp_pid  = cur_pid_q;

endmodule

// File: hw/watchdog.sv
// ################################################
// Watchdog timer
// Software-loaded down-counter. Flags an error for one
// cycle when it runs out; zero means disabled.
// ################################################

`timescale 1ns/100ps

module watchdog (
  input  logic    clk,
  input  logic    sys_rst,
  dev_bus_if.dev  bus,
  output logic    err
);
  import sys_ctrl_pkg::*;

  wd_cnt_t cnt_q;                                // remaining count
  logic    err_q;
  logic    wr;

  assign wr = bus.sel & bus.we;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cnt_q <= '0;
      err_q <= 1'b0;
    end else begin
      if (wr) begin
        cnt_q <= bus.wdata[WD_CNT_W-1:0];        // reload
        err_q <= 1'b0;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - wd_cnt_t'(1);
        err_q <= (cnt_q == wd_cnt_t'(1));        // hits zero now
      end else begin
        err_q <= 1'b0;
      end
    end
  end

  assign err = err_q;

  // count zero-extended to a bus word
  assign bus.rdata = word_t'(cnt_q);

endmodule

// File: hw/stack_monitor.sv
// ################################################
// Stack limit monitor
// Flags overflow while the stack pointer is below
// the programmed limit; a zero limit disables it
// ################################################

`timescale 1ns/100ps

module stack_monitor (
  input  logic                      clk,
  input  logic                      sys_rst,
  dev_bus_if.dev                    bus,
  input  sys_ctrl_pkg::code_addr_t  sp,
  output logic                      err
);
  import sys_ctrl_pkg::*;

  code_addr_t limit_q;
  logic       ovf_q;                             // registered compare
  logic       wr;

  assign wr = bus.sel & bus.we;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      limit_q <= '0;
      ovf_q   <= 1'b0;
    end else begin
      if (wr) begin
        limit_q <= bus.wdata[$bits(code_addr_t)-1:0];
      end
      ovf_q <= (limit_q != '0) && (sp < limit_q); // stack grows down
    end
  end

  assign err = ovf_q;

  always_comb begin
    bus.rdata = '0;
    bus.rdata[$bits(code_addr_t)-1:0] = limit_q;
    bus.rdata[$bits(word_t)-1]        = ovf_q;    // overflow flag
  end

endmodule

// File: hw/io_decode.sv
// ################################################
// I/O decoder
// Turns the strobe bus into device selects and picks
// the read data of the addressed device
// ################################################

`timescale 1ns/100ps

module io_decode (
  input  logic                    io_stb,
  input  logic                    io_we,
  input  io_map_pkg::io_addr_t    io_addr,
  input  sys_ctrl_pkg::word_t     io_wdata,
  output sys_ctrl_pkg::word_t     io_rdata,
  output logic                    io_ack,
  dev_bus_if.ctrl                 scs,
  dev_bus_if.ctrl                 wd,
  dev_bus_if.ctrl                 stk
);
  import io_map_pkg::*;

  // control block owns two words
  assign scs.sel = io_stb & ((io_addr == ADDR_SCS_CTRL) | (io_addr == ADDR_SCS_ERR));
  assign wd.sel  = io_stb & (io_addr == ADDR_WD);
  assign stk.sel = io_stb & (io_addr == ADDR_STACK);

  assign scs.we    = io_we;
  assign wd.we     = io_we;
  assign stk.we    = io_we;

  assign scs.sub   = io_addr[0];
  assign wd.sub    = io_addr[0];
  assign stk.sub   = io_addr[0];

  assign scs.wdata = io_wdata;
  assign wd.wdata  = io_wdata;
  assign stk.wdata = io_wdata;

  always_comb begin
    io_rdata = '0;                               // idle bus reads zero
    if (io_stb) begin
      unique case (io_addr)
        ADDR_SCS_CTRL,
        ADDR_SCS_ERR:  io_rdata = scs.rdata;
        ADDR_WD:       io_rdata = wd.rdata;
        ADDR_STACK:    io_rdata = stk.rdata;
      endcase
    end
  end

  assign io_ack = io_stb;                        // no wait states

endmodule

// File: hw/sys_ctrl_top.sv
// ################################################
// System control top level
// Joins the I/O decoder, the control registers and
// the watchdog and stack error sources
// ################################################

`timescale 1ns/100ps

module sys_ctrl_top (
  input  logic                                  clk,
  input  logic                                  rst_trig0,
  input  logic                                  io_stb,
  input  logic                                  io_we,
  input  io_map_pkg::io_addr_t                  io_addr,
  input  sys_ctrl_pkg::word_t                   io_wdata,
  output sys_ctrl_pkg::word_t                   io_rdata,
  output logic                                  io_ack,
  input  sys_ctrl_pkg::code_addr_t              pc,
  input  sys_ctrl_pkg::code_addr_t              sp,
  input  logic [sys_ctrl_pkg::ERR_LINES-3:0]    err_ext,
  output logic                                  sys_rst,
  output sys_ctrl_pkg::pid_t                    cp_pid
);
  import sys_ctrl_pkg::*;

  logic [ERR_LINES-1:0] err_sig;
  logic                 wd_err;
  logic                 stk_err;

  dev_bus_if scs_bus ();
  dev_bus_if wd_bus ();
  dev_bus_if stk_bus ();

  assign err_sig[ERR_WD]                  = wd_err;
  assign err_sig[ERR_STACK]               = stk_err;
  assign err_sig[ERR_LINES-1:ERR_STACK+1] = err_ext;  // external lines 2..7

  io_decode u_io_decode (
    .io_stb   (io_stb),
    .io_we    (io_we),
    .io_addr  (io_addr),
    .io_wdata (io_wdata),
    .io_rdata (io_rdata),
    .io_ack   (io_ack),
    .scs      (scs_bus.ctrl),
    .wd       (wd_bus.ctrl),
    .stk      (stk_bus.ctrl)
  );

  scs_regs u_scs_regs (
    .clk       (clk),
    .rst_trig0 (rst_trig0),
    .bus       (scs_bus.dev),
    .err_sig   (err_sig),
    .err_addr  (pc),
    .sys_rst   (sys_rst),
    .cp_pid    (cp_pid)
  );

  watchdog u_watchdog (
    .clk     (clk),
    .sys_rst (sys_rst),
    .bus     (wd_bus.dev),
    .err     (wd_err)
  );

  stack_monitor u_stack_monitor (
    .clk     (clk),
    .sys_rst (sys_rst),
    .bus     (stk_bus.dev),
    .sp      (sp),
    .err     (stk_err)
  );

endmodule

// File: tests/tb_clk_gen.sv
// ################################################
// Testbench clock generator
// Free-running clock with an even period in ns
// ################################################

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;         // half period per phase
  end
endmodule

// File: tests/tb_sys_ctrl.sv
// ################################################
// System control testbench
// Random bus and error stimulus against a cycle model
// of the control block, watchdog and stack monitor
// ################################################

`timescale 1ns/100ps

module tb_sys_ctrl;
  import sys_ctrl_pkg::*;
  import io_map_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 16;
  localparam int EXT_W      = ERR_LINES - 2;     // external error lines
  localparam int N_RW       = 40;
  localparam int N_ERR      = 10;
  localparam int N_WD       = 6;
  localparam int WD_MAX     = 64;
  localparam int N_STK      = 6;
  localparam int RUN_CYCLES = RST_CYCLES + N_RW * 2 + N_ERR * 6 + N_WD * (WD_MAX + 8)
                              + N_STK * 18 + 40;
  localparam int TIMEOUT_NS = 2 * RUN_CYCLES * CLK_PERIOD + 1000;

  logic             clk;
  logic             rst_trig0;
  logic             io_stb;
  logic             io_we;
  io_addr_t         io_addr;
  word_t            io_wdata;
  word_t            io_rdata;
  logic             io_ack;
  code_addr_t       pc;
  code_addr_t       sp;
  logic [EXT_W-1:0] err_ext;
  logic             sys_rst;
  pid_t             cp_pid;

  // reference model
  scs_bits_t  m_scs      = '0;
  pid_t       m_cur_pid  = '0;
  pid_t       m_err_pid  = '0;
  code_addr_t m_err_addr = '0;
  err_no_t    m_err_no   = '0;
  logic       m_trig_a   = 1'b0;
  logic       m_trig_b   = 1'b0;
  wd_cnt_t    m_wd_cnt   = '0;
  logic       m_wd_err   = 1'b0;
  code_addr_t m_limit    = '0;
  logic       m_ovf      = 1'b0;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.clk(clk));

  sys_ctrl_top u_dut (
    .clk       (clk),
    .rst_trig0 (rst_trig0),
    .io_stb    (io_stb),
    .io_we     (io_we),
    .io_addr   (io_addr),
    .io_wdata  (io_wdata),
    .io_rdata  (io_rdata),
    .io_ack    (io_ack),
    .pc        (pc),
    .sp        (sp),
    .err_ext   (err_ext),
    .sys_rst   (sys_rst),
    .cp_pid    (cp_pid)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    end
  endtask

  // next model state from the inputs seen at this edge
  task automatic model_edge();
    logic [ERR_LINES-1:0] lines;
    logic                 src_rst;
    logic                 quiet;
    logic                 wr;
    int                   hi;
    lines   = {err_ext, m_ovf, m_wd_err};
    src_rst = rst_trig0 | m_trig_a | m_trig_b;
    quiet   = ~(m_scs[SCS_RST_BIT] | m_trig_a | m_trig_b);
    wr      = io_stb & io_we;
    hi      = -1;
    for (int i = 0; i < ERR_LINES; i++) begin
      if (lines[i]) begin
        hi = i;
      end
    end
    if (src_rst) begin
      m_wd_cnt = '0;
      m_wd_err = 1'b0;
      m_limit  = '0;
      m_ovf    = 1'b0;
    end else begin
      m_wd_err = !(wr && io_addr == ADDR_WD) && (m_wd_cnt == wd_cnt_t'(1));
      if (wr && io_addr == ADDR_WD) begin
        m_wd_cnt = io_wdata[WD_CNT_W-1:0];
      end else if (m_wd_cnt != '0) begin
        m_wd_cnt = m_wd_cnt - wd_cnt_t'(1);
      end
      m_ovf = (m_limit != '0) && (sp < m_limit);  // compare uses the old limit
      if (wr && io_addr == ADDR_STACK) begin
        m_limit = io_wdata[23:0];
      end
    end
    if (rst_trig0) begin
      {m_scs, m_cur_pid, m_err_pid, m_err_addr, m_err_no} = '0;
      m_trig_a = 1'b0;
      m_trig_b = 1'b0;
    end else begin
      m_trig_b           = m_trig_a;
      m_trig_a           = m_scs[SCS_RST_BIT];
      m_scs[SCS_RST_BIT] = 1'b0;
      if (wr && io_addr == ADDR_SCS_CTRL) begin
        m_scs     = io_wdata[7:0];
        m_cur_pid = io_wdata[CUR_PID_LSB +: 5];
        m_err_pid = io_wdata[ERR_PID_LSB +: 5];
      end else if (wr && io_addr == ADDR_SCS_ERR) begin
        m_err_addr = io_wdata[31:8];
        m_err_no   = io_wdata[7:0];
      end else if (quiet && hi >= 0) begin
        m_scs[SCS_RST_BIT] = 1'b1;
        m_err_addr         = pc;
        m_err_no           = err_no_t'(ERR_NO_BASE + hi);
      end
    end
  endtask

  task automatic check_outputs(input string name);
    word_t exp_rd;
    exp_rd = '0;
    if (io_stb) begin
      case (io_addr)
        ADDR_SCS_CTRL: exp_rd = {14'd0, m_err_pid, m_cur_pid, m_scs};
        ADDR_SCS_ERR:  exp_rd = {m_err_addr, m_err_no};
        ADDR_WD:       exp_rd = {16'd0, m_wd_cnt};
        default:       exp_rd = {m_ovf, 7'd0, m_limit};
      endcase
    end
    compare({name, " rdata"}, exp_rd, io_rdata);
    compare({name, " ack"}, word_t'(io_stb), word_t'(io_ack));
    compare({name, " sys_rst"}, word_t'(rst_trig0 | m_trig_a | m_trig_b), word_t'(sys_rst));
    compare({name, " cp_pid"}, word_t'(m_cur_pid), word_t'(cp_pid));
  endtask

  // model at the rising edge and checks plus a new pc at the falling edge
  task automatic step(input string name);
    @(posedge clk);
    model_edge();
    @(negedge clk);
    check_outputs(name);
    pc = code_addr_t'($urandom);
  endtask

  task automatic bus_write(input io_addr_t a, input word_t d, input string name);
    io_stb   = 1'b1;
    io_we    = 1'b1;
    io_addr  = a;
    io_wdata = d;
    step(name);
    io_stb = 1'b0;
    io_we  = 1'b0;
  endtask

  task automatic bus_read(input io_addr_t a, output word_t d, input string name);
    io_stb  = 1'b1;
    io_we   = 1'b0;
    io_addr = a;
    step(name);
    d      = io_rdata;
    io_stb = 1'b0;
  endtask

  task automatic wait_sys_rst(input string name, input int limit, output int n);
    n = 0;
    while (sys_rst !== 1'b1) begin
      if (n >= limit) begin
        abort_run($sformatf("sys_rst did not rise within %0d cycles in %s", limit, name));
      end
      step(name);
      n++;
    end
  endtask

  task automatic pulse_len(input string name, output int n);
    n = 0;
    while (sys_rst === 1'b1 && n < 8) begin
      step(name);
      n++;
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    abort_run($sformatf("timeout: tests did not finish within %0d ns", TIMEOUT_NS));
  end

  initial begin
    word_t            d;
    word_t            rd;
    code_addr_t       cap_pc;
    code_addr_t       lim;
    logic [EXT_W-1:0] sub;
    logic [3:0]       rst_seen;
    int               hi;
    int               n;
    int               cnt;
    void'($urandom(32'h1801));
    rst_trig0 = 1'b1;
    io_stb    = 1'b0;
    io_we     = 1'b0;
    io_addr   = '0;
    io_wdata  = '0;
    pc        = '0;
    sp        = '1;                              // top of memory stays above any limit
    err_ext   = '0;
    repeat (RST_CYCLES) step("reset");
    rst_trig0 = 1'b0;
    step("idle");

    for (int i = 0; i < N_RW; i++) begin
      d = $urandom;
      if ($urandom % 2 == 0) begin
        d[SCS_RST_BIT] = 1'b0;
        bus_write(ADDR_SCS_CTRL, d, "ctrl_rw");
        bus_read(ADDR_SCS_CTRL, rd, "ctrl_rw");
        compare("ctrl_rw readback", {14'd0, d[17:0]}, rd);
        compare("ctrl_rw cp_pid", word_t'(d[12:8]), word_t'(cp_pid));
      end else begin
        bus_write(ADDR_SCS_ERR, d, "err_rw");
        bus_read(ADDR_SCS_ERR, rd, "err_rw");
        compare("err_rw readback", d, rd);
      end
    end

    for (int i = 0; i < N_ERR; i++) begin
      sub = EXT_W'($urandom % 63 + 1);
      hi  = 0;
      for (int j = 0; j < EXT_W; j++) begin
        if (sub[j]) begin
          hi = j;
        end
      end
      cap_pc  = pc;
      err_ext = sub;
      step("ext_err");
      rst_seen[3] = sys_rst;
      for (int k = 2; k >= 0; k--) begin
        err_ext = EXT_W'($urandom % 63 + 1);    // lost while reset pending
        step("ext_err blocked");
        rst_seen[k] = sys_rst;
      end
      err_ext = '0;
      compare("ext_err sys_rst pulse", word_t'(4'b0110), word_t'(rst_seen));
      bus_read(ADDR_SCS_ERR, rd, "ext_err record");
      compare("ext_err record", {cap_pc, err_no_t'(ERR_NO_BASE + ERR_STACK + 1 + hi)}, rd);
    end

    for (int i = 0; i < N_WD; i++) begin
      cnt = 1 + int'($urandom % WD_MAX);
      bus_write(ADDR_WD, word_t'(cnt), "wd_load");
      bus_read(ADDR_WD, rd, "wd_running");
      compare("wd_count running", word_t'(cnt - 1), rd);
      wait_sys_rst("wd_expire", WD_MAX + 8, n);
      compare("wd_expire delay", word_t'(cnt + 1), word_t'(n));
      pulse_len("wd_expire", n);
      compare("wd_expire pulse", 32'd2, word_t'(n));
      bus_read(ADDR_SCS_ERR, rd, "wd_errno");
      compare("wd_errno", word_t'(ERR_NO_BASE + ERR_WD), word_t'(rd[7:0]));
      bus_read(ADDR_WD, rd, "wd_count");
      compare("wd_count after reset", 32'd0, rd);
    end

    for (int i = 0; i < N_STK; i++) begin
      lim = code_addr_t'(32'h100 + $urandom % 32'h1_0000);
      sp  = lim;
      bus_write(ADDR_STACK, word_t'(lim), "stk_limit");
      bus_read(ADDR_STACK, rd, "stk_limit");
      compare("stk_limit readback", word_t'(lim), rd);
      sp = lim - code_addr_t'(1 + $urandom % 32'h100);
      bus_read(ADDR_STACK, rd, "stk_flag");
      compare("stk_flag readback", {1'b1, 7'd0, lim}, rd);
      wait_sys_rst("stk_ovf", 16, n);
      compare("stk_ovf delay", 32'd2, word_t'(n));
      pulse_len("stk_ovf", n);
      compare("stk_ovf pulse", 32'd2, word_t'(n));
      bus_read(ADDR_SCS_ERR, rd, "stk_errno");
      compare("stk_errno", word_t'(ERR_NO_BASE + ERR_STACK), word_t'(rd[7:0]));
      bus_read(ADDR_STACK, rd, "stk_limit cleared");
      compare("stk_limit cleared", 32'd0, rd);
      repeat (8) begin
        step("stk_quiet");
        compare("stk_quiet sys_rst", 32'd0, word_t'(sys_rst));
      end
      sp = '1;
    end

    d = $urandom;
    d[SCS_RST_BIT] = 1'b1;
    bus_write(ADDR_SCS_CTRL, d, "sw_reset");
    wait_sys_rst("sw_reset", 4, n);
    compare("sw_reset delay", 32'd1, word_t'(n));
    pulse_len("sw_reset", n);
    compare("sw_reset pulse", 32'd2, word_t'(n));
    bus_read(ADDR_SCS_CTRL, rd, "sw_reset ctrl");
    d[SCS_RST_BIT] = 1'b0;
    compare("sw_reset ctrl kept", {14'd0, d[17:0]}, rd);

    d = $urandom;
    d[SCS_RST_BIT] = 1'b0;
    bus_write(ADDR_SCS_CTRL, d, "pre_rst");
    bus_write(ADDR_SCS_ERR, $urandom, "pre_rst");
    bus_write(ADDR_WD, 32'd1000, "pre_rst");
    bus_write(ADDR_STACK, 32'd1, "pre_rst");
    rst_trig0 = 1'b1;
    repeat (3) step("mid_rst");
    rst_trig0 = 1'b0;
    step("mid_rst release");
    for (int a = 0; a < 4; a++) begin
      bus_read(io_addr_t'(a), rd, "mid_rst clear");
      compare("mid_rst clear", 32'd0, rd);
    end
    compare("mid_rst cp_pid", 32'd0, word_t'(cp_pid));

    $display("sim passed");
    $finish;
  end

endmodule

// File: verilog.f
hw/sys_ctrl_pkg.sv
hw/io_map_pkg.sv
hw/dev_bus_if.sv
hw/scs_regs.sv
hw/watchdog.sv
hw/stack_monitor.sv
hw/io_decode.sv
hw/sys_ctrl_top.sv
tests/tb_clk_gen.sv
tests/tb_sys_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the system control testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_sys_ctrl -f verilog.f \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "FAIL: Verilator build error"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "FAIL: testbench reported an error, see $LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "FAIL: simulation exited with status $run_status"
  exit 1
fi
echo "PASS"
exit 0
